/* hw/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////

// cpu and memory word sizes
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// address split, tag | set | line | byte offset
`define CACHE_TAG_W 17
`define CACHE_SET_W 6
`define CACHE_WAY_W 2
`define CACHE_OFFSET_W 7

// words within one 128 byte line
`define CACHE_WORD_IDX_W 5
`define CACHE_WORDS_PER_LINE 32

`endif

/* hw/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;
    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_SET_W-1:0] set_idx_t;
    typedef logic [`CACHE_WAY_W-1:0] way_idx_t;
    typedef logic [`CACHE_WORD_IDX_W-1:0] word_idx_t;

    // one strobe per byte lane of a word
    typedef logic [`CACHE_WORD_W/8-1:0] byte_en_t;

    ////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////

    // READY serves hits, REPLACE fills a missed line from memory
    typedef enum logic {
        READY   = 1'b0,
        REPLACE = 1'b1
    } cache_state_t;

endpackage

/* hw/line_access_if.sv */
`timescale 1ns/1ns

interface line_access_if;

    // line select
    cache_pkg::set_idx_t  set_idx;
    cache_pkg::way_idx_t  way_idx;
    cache_pkg::word_idx_t word_idx;
    cache_pkg::tag_t      tag;

    // write payload
    cache_pkg::word_t     wdata;
    cache_pkg::byte_en_t  byte_en;

    // strobes from the controller
    logic                 data_write;
    logic                 data_read;
    logic                 tag_write;

    // lookup result
    logic                 hit;

    modport controller (
        output set_idx, way_idx, word_idx, tag, wdata, byte_en,
        output data_write, data_read, tag_write,
        input  hit
    );

    modport tag_store (
        input  set_idx, way_idx, tag, tag_write,
        output hit
    );

    modport data_store (
        input  set_idx, way_idx, word_idx, wdata, byte_en, data_write, data_read
    );

endinterface

/* hw/cache_controller.sv */
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_controller (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cache_pkg::addr_t     cpu_addr,
    input  cache_pkg::word_t     cpu_data_in,
    input  cache_pkg::byte_en_t  cpu_wstb,
    input  logic                 cpu_we,
    input  logic                 cpu_re,
    input  cache_pkg::word_t     mem_data_in,
    input  logic                 mem_data_valid,
    input  logic                 mem_last,
    output logic                 miss,
    output cache_pkg::addr_t     mem_line_addr,
    line_access_if.controller    acc
);

    // bits below the word index select a byte inside the word
    localparam int LANE_W = `CACHE_OFFSET_W - `CACHE_WORD_IDX_W;

    cache_pkg::cache_state_t state_q;

    // line under replacement
    cache_pkg::tag_t      tag_q;
    cache_pkg::set_idx_t  set_q;
    cache_pkg::way_idx_t  way_q;
    cache_pkg::word_idx_t fill_cnt_q;

    // fields of the current cpu address
    cache_pkg::tag_t      cpu_tag;
    cache_pkg::set_idx_t  cpu_set;
    cache_pkg::way_idx_t  cpu_way;
    cache_pkg::word_idx_t cpu_word;

    logic req;
    logic lookup_miss;

    assign cpu_tag  = cpu_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign cpu_set  = cpu_addr[`CACHE_OFFSET_W+`CACHE_WAY_W +: `CACHE_SET_W];
    assign cpu_way  = cpu_addr[`CACHE_OFFSET_W +: `CACHE_WAY_W];
    assign cpu_word = cpu_addr[LANE_W +: `CACHE_WORD_IDX_W];

    assign req         = cpu_we | cpu_re;
    assign lookup_miss = req & ~acc.hit;

    ////////////////////////////////////////////////////////////
    // storage access routing
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (state_q == cache_pkg::READY) begin
            // lookup and hit access straight from the cpu address
            acc.set_idx    = cpu_set;
            acc.way_idx    = cpu_way;
            acc.word_idx   = cpu_word;
            acc.tag        = cpu_tag;
            acc.wdata      = cpu_data_in;
            acc.byte_en    = cpu_wstb;
            acc.data_write = cpu_we & acc.hit;
            acc.data_read  = cpu_re & acc.hit;
            acc.tag_write  = 1'b0;
        end else begin
            // fill the latched line word by word, full strobes
            acc.set_idx    = set_q;
            acc.way_idx    = way_q;
            acc.word_idx   = fill_cnt_q;
            acc.tag        = tag_q;
            acc.wdata      = mem_data_in;
            acc.byte_en    = '1;
            acc.data_write = mem_data_valid;
            acc.data_read  = 1'b0;
            acc.tag_write  = mem_data_valid & mem_last;
        end
    end

    ////////////////////////////////////////////////////////////
    // state and fill counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q    <= cache_pkg::READY;
            fill_cnt_q <= '0;
        end else begin
            case (state_q)
                cache_pkg::READY: begin
                    if (lookup_miss) begin
                        state_q    <= cache_pkg::REPLACE;
                        fill_cnt_q <= '0;
                    end
                end
                cache_pkg::REPLACE: begin
                    if (mem_data_valid) begin
                        fill_cnt_q <= fill_cnt_q + 1'b1;
                        // word 31 closes the fill
                        if (mem_last) begin
                            state_q <= cache_pkg::READY;
                        end
                    end
                end
            endcase
        end
    end

    // remember which line the missed request wants
    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::READY && lookup_miss) begin
            tag_q <= cpu_tag;
            set_q <= cpu_set;
            way_q <= cpu_way;
        end
    end

    assign miss          = (state_q == cache_pkg::REPLACE);
    assign mem_line_addr = {tag_q, set_q, way_q, {`CACHE_OFFSET_W{1'b0}}};

endmodule

/* hw/cache_tag_store.sv */
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_tag_store (
    input  logic              clk,
    input  logic              reset_n,
    line_access_if.tag_store  acc
);

    // one entry per set and line number
    localparam int IDX_W = `CACHE_SET_W + `CACHE_WAY_W;
    localparam int LINES = 1 << IDX_W;

    cache_pkg::tag_t   tags_q [LINES];
    logic [LINES-1:0]  valid_q;

    logic [IDX_W-1:0]  line_idx;
    cache_pkg::tag_t   stored_tag;
    logic              stored_valid;

    assign line_idx     = {acc.set_idx, acc.way_idx};
    assign stored_tag   = tags_q[line_idx];
    assign stored_valid = valid_q[line_idx];

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    // combinational so the controller can act in the request cycle
    assign acc.hit = stored_valid && (stored_tag == acc.tag);

    ////////////////////////////////////////////////////////////
    // install
    ////////////////////////////////////////////////////////////

    // valid bits start cleared, nothing hits after reset
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= '0;
        end else if (acc.tag_write) begin
            valid_q[line_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.tag_write) begin
            tags_q[line_idx] <= acc.tag;
        end
    end

endmodule

/* hw/cache_data_store.sv */
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_data_store (
    input  logic               clk,
    input  logic               reset_n,
    line_access_if.data_store  acc,
    output cache_pkg::word_t   rdata
);

    localparam int SETS           = 1 << `CACHE_SET_W;
    localparam int WAYS           = 1 << `CACHE_WAY_W;
    localparam int LINE_BYTES     = 1 << `CACHE_OFFSET_W;
    localparam int BYTES_PER_WORD = `CACHE_WORD_W / 8;
    localparam int LANE_W         = `CACHE_OFFSET_W - `CACHE_WORD_IDX_W;

    // 64 sets x 4 lines x 128 bytes
    logic [7:0] bytes_q [SETS][WAYS][LINE_BYTES];

    // first byte of the addressed word
    logic [`CACHE_OFFSET_W-1:0] byte_base;

    assign byte_base = {acc.word_idx, {LANE_W{1'b0}}};

    ////////////////////////////////////////////////////////////
    // strobed write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (acc.data_write) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                // lanes without a strobe keep their old byte
                if (acc.byte_en[b]) begin
                    bytes_q[acc.set_idx][acc.way_idx][byte_base + `CACHE_OFFSET_W'(b)]
                        <= acc.wdata[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // registered read
    ////////////////////////////////////////////////////////////

    // little endian, byte 0 of the word lands in bits 7:0
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rdata <= '0;
        end else if (acc.data_read) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                rdata[8*b +: 8]
                    <= bytes_q[acc.set_idx][acc.way_idx][byte_base + `CACHE_OFFSET_W'(b)];
            end
        end
    end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ns

module cache_top (
    input  logic                 clk,
    input  logic                 reset_n,

    // cpu side
    input  cache_pkg::addr_t     cpu_addr,
    input  cache_pkg::word_t     cpu_data_in,
    input  cache_pkg::byte_en_t  cpu_wstb,
    input  logic                 cpu_we,
    input  logic                 cpu_re,
    output cache_pkg::word_t     cpu_data_out,
    output logic                 miss,

    // memory side, line fill only
    output cache_pkg::addr_t     mem_line_addr,
    input  cache_pkg::word_t     mem_data_in,
    input  logic                 mem_data_valid,
    input  logic                 mem_last
);

    ////////////////////////////////////////////////////////////
    // shared line access bus
    ////////////////////////////////////////////////////////////

    line_access_if acc ();

    ////////////////////////////////////////////////////////////
    // controller
    ////////////////////////////////////////////////////////////

    cache_controller u_controller (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_addr       (cpu_addr),
        .cpu_data_in    (cpu_data_in),
        .cpu_wstb       (cpu_wstb),
        .cpu_we         (cpu_we),
        .cpu_re         (cpu_re),
        .mem_data_in    (mem_data_in),
        .mem_data_valid (mem_data_valid),
        .mem_last       (mem_last),
        .miss           (miss),
        .mem_line_addr  (mem_line_addr),
        .acc            (acc)
    );

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // tags and valid bits, gives hit back to the controller
    cache_tag_store u_tag_store (
        .clk     (clk),
        .reset_n (reset_n),
        .acc     (acc)
    );

    // line bytes, read data goes straight out to the cpu
    cache_data_store u_data_store (
        .clk     (clk),
        .reset_n (reset_n),
        .acc     (acc),
        .rdata   (cpu_data_out)
    );

endmodule

/* tests/cache_assertions.sv */
`timescale 1ns/1ns

module cache_assertions (
    input logic clk,
    input logic reset_n,
    input logic cpu_we,
    input logic cpu_re,
    input logic miss,
    input logic mem_data_valid,
    input logic mem_last
);

    ////////////////////////////////////////////////////////////
    // cpu request rules
    ////////////////////////////////////////////////////////////

    // a request is a read or a write, never both
    a_one_request : assert property (@(posedge clk) disable iff (!reset_n)
        !(cpu_we && cpu_re))
        else $error("cpu_we and cpu_re high in the same cycle");

    // cpu has to wait for the fill to end
    a_no_request_in_fill : assert property (@(posedge clk) disable iff (!reset_n)
        miss |-> !(cpu_we || cpu_re))
        else $error("cpu request while miss is high");

    ////////////////////////////////////////////////////////////
    // memory fill rules
    ////////////////////////////////////////////////////////////

    // last word marker only rides on a valid word
    a_last_needs_valid : assert property (@(posedge clk) disable iff (!reset_n)
        mem_last |-> mem_data_valid)
        else $error("mem_last without mem_data_valid");

    // word 31 closes the fill on the edge that samples it
    a_miss_drops : assert property (@(posedge clk) disable iff (!reset_n)
        (miss && mem_data_valid && mem_last) |=> !miss)
        else $error("miss still high after the last fill word");

endmodule

bind cache_controller cache_assertions u_assertions (
    .clk            (clk),
    .reset_n        (reset_n),
    .cpu_we         (cpu_we),
    .cpu_re         (cpu_re),
    .miss           (miss),
    .mem_data_valid (mem_data_valid),
    .mem_last       (mem_last)
);

/* tests/cache_tb.sv */
`timescale 1ns/1ns

`include "cache_params.svh"

module cache_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int MAX_GAP      = 3;
    localparam int RANDOM_OPS   = 300;
    localparam int DIRECTED_OPS = 32;
    localparam int WORDS        = `CACHE_WORDS_PER_LINE;
    localparam int LINE_BYTES   = 1 << `CACHE_OFFSET_W;
    localparam int LINES        = 1 << (`CACHE_SET_W + `CACHE_WAY_W);
    // worst case per operation is a full fill with maximum gaps plus the two pulses
    localparam int FILL_CYCLES  = WORDS * (MAX_GAP + 1) + 8;
    localparam longint WATCHDOG_NS =
        longint'(RANDOM_OPS + DIRECTED_OPS) * FILL_CYCLES * CLK_PERIOD;
    localparam cache_pkg::word_t MEM_PATTERN = 32'h5a3c_96e1;

    logic                clk;
    logic                reset_n;
    cache_pkg::addr_t    cpu_addr;
    cache_pkg::word_t    cpu_data_in;
    cache_pkg::byte_en_t cpu_wstb;
    logic                cpu_we;
    logic                cpu_re;
    cache_pkg::word_t    cpu_data_out;
    logic                miss;
    cache_pkg::addr_t    mem_line_addr;
    cache_pkg::word_t    mem_data_in;
    logic                mem_data_valid;
    logic                mem_last;

    // reference cache indexed by {set, line number}
    cache_pkg::tag_t model_tag [LINES];
    logic            model_valid [LINES];
    logic [7:0]      model_bytes [LINES][LINE_BYTES];

    cache_top UUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_addr       (cpu_addr),
        .cpu_data_in    (cpu_data_in),
        .cpu_wstb       (cpu_wstb),
        .cpu_we         (cpu_we),
        .cpu_re         (cpu_re),
        .cpu_data_out   (cpu_data_out),
        .miss           (miss),
        .mem_line_addr  (mem_line_addr),
        .mem_data_in    (mem_data_in),
        .mem_data_valid (mem_data_valid),
        .mem_last       (mem_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // memory rule and cache model
    ////////////////////////////////////////////////////////////

    function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
        return a ^ MEM_PATTERN;
    endfunction

    function automatic cache_pkg::addr_t line_base(input cache_pkg::addr_t a);
        return {a[31:7], 7'b0};
    endfunction

    // tag 31:15, set 14:9, line number 8:7
    function automatic int line_of(input cache_pkg::addr_t a);
        return int'(a[14:7]);
    endfunction

    function automatic logic model_hit(input cache_pkg::addr_t a);
        return model_valid[line_of(a)] && (model_tag[line_of(a)] == a[31:15]);
    endfunction

    function automatic cache_pkg::word_t model_read(input cache_pkg::addr_t a);
        cache_pkg::word_t w;
        int base;
        base = {a[6:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = model_bytes[line_of(a)][base + b];
        end
        return w;
    endfunction

    task automatic model_write(input cache_pkg::addr_t a, input cache_pkg::word_t wd,
                               input cache_pkg::byte_en_t stb);
        int base;
        base = {a[6:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (stb[b]) begin
                model_bytes[line_of(a)][base + b] = wd[8*b +: 8];
            end
        end
    endtask

    // a refill replaces the whole line and drops earlier writes
    task automatic model_install(input cache_pkg::addr_t a);
        cache_pkg::word_t w;
        for (int i = 0; i < WORDS; i++) begin
            w = mem_word(line_base(a) + cache_pkg::addr_t'(4 * i));
            for (int b = 0; b < 4; b++) begin
                model_bytes[line_of(a)][4 * i + b] = w[8*b +: 8];
            end
        end
        model_tag[line_of(a)]   = a[31:15];
        model_valid[line_of(a)] = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("Verification failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail: time %0t, %s = %h, expected %h", $time, name, got, exp);
            fail_run("read data does not match the cache model");
        end
    endtask

    task automatic check_miss(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail: time %0t, miss = %b, expected %b", $time, got, exp);
            fail_run("miss decision does not match the cache model");
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail: time %0t, %s = %h, expected %h", $time, name, got, exp);
            fail_run("line address of the fill is wrong");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // one cycle request pulse with outputs sampled at the following falling edge
    task automatic pulse_request(input logic is_write, input cache_pkg::addr_t a,
                                 input cache_pkg::word_t wd, input cache_pkg::byte_en_t stb);
        @(posedge clk);
        cpu_addr    <= a;
        cpu_data_in <= wd;
        cpu_wstb    <= stb;
        cpu_we      <= is_write;
        cpu_re      <= ~is_write;
        @(posedge clk);
        cpu_we <= 1'b0;
        cpu_re <= 1'b0;
        @(negedge clk);
    endtask

    // memory side of a fill sends the words in order with random idle gaps
    task automatic serve_fill(input cache_pkg::addr_t base);
        int gap;
        for (int i = 0; i < WORDS; i++) begin
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) begin
                @(posedge clk);
                mem_data_valid <= 1'b0;
                mem_last       <= 1'b0;
                @(negedge clk);
                check_miss(miss, 1'b1);
            end
            @(posedge clk);
            mem_data_valid <= 1'b1;
            mem_data_in    <= mem_word(base + cache_pkg::addr_t'(4 * i));
            mem_last       <= (i == WORDS - 1);
            @(negedge clk);
            check_miss(miss, 1'b1);
        end
        @(posedge clk);
        mem_data_valid <= 1'b0;
        mem_last       <= 1'b0;
        @(negedge clk);
        check_miss(miss, 1'b0);
    endtask

    // full access that refills on a miss and retries like the cpu would
    task automatic access(input logic is_write, input cache_pkg::addr_t a,
                          input cache_pkg::word_t wd, input cache_pkg::byte_en_t stb);
        logic hit_expected;
        hit_expected = model_hit(a);
        pulse_request(is_write, a, wd, stb);
        check_miss(miss, ~hit_expected);
        if (!hit_expected) begin
            check_addr("mem_line_addr", mem_line_addr, line_base(a));
            serve_fill(line_base(a));
            model_install(a);
            pulse_request(is_write, a, wd, stb);
            check_miss(miss, 1'b0);
        end
        if (is_write) begin
            model_write(a, wd, stb);
        end else begin
            check_word("cpu_data_out", cpu_data_out, model_read(a));
        end
    endtask

    function automatic cache_pkg::tag_t pool_tag(input int k);
        case (k)
            0:       return 17'h00012;
            1:       return 17'h1a2b3;
            default: return 17'h0f00d;
        endcase
    endfunction

    // few tags and sets so that hits and conflicts both happen often
    function automatic cache_pkg::addr_t rand_addr();
        cache_pkg::tag_t tag;
        tag = pool_tag($urandom_range(0, 2));
        return {tag, cache_pkg::set_idx_t'($urandom_range(0, 3)),
                cache_pkg::way_idx_t'($urandom_range(0, 3)),
                cache_pkg::word_idx_t'($urandom_range(0, 31)), 2'b00};
    endfunction

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the test sequence finished");
    end

    initial begin
        cache_pkg::addr_t a;
        cache_pkg::addr_t a_base;
        cache_pkg::addr_t a_conf;
        void'($urandom(32'h6096e3e1));
        for (int i = 0; i < LINES; i++) begin
            model_valid[i] = 1'b0;
        end
        reset_n        <= 1'b0;
        cpu_addr       <= '0;
        cpu_data_in    <= '0;
        cpu_wstb       <= '0;
        cpu_we         <= 1'b0;
        cpu_re         <= 1'b0;
        mem_data_in    <= '0;
        mem_data_valid <= 1'b0;
        mem_last       <= 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_miss(miss, 1'b0);
        check_word("cpu_data_out", cpu_data_out, '0);

        // cold line then reads across it
        a_base = {pool_tag(0), 6'd5, 2'd1, 7'd0};
        access(1'b0, a_base + 32'd12, '0, '0);
        for (int i = 0; i < 8; i++) begin
            a = a_base + (cache_pkg::addr_t'($urandom_range(0, 31)) << 2);
            access(1'b0, a, '0, '0);
            check_word("cpu_data_out", cpu_data_out, mem_word(a));
        end

        // strobed write hits followed by reads
        for (int i = 0; i < 4; i++) begin
            a = a_base + (cache_pkg::addr_t'($urandom_range(0, 31)) << 2);
            access(1'b1, a, $urandom, cache_pkg::byte_en_t'($urandom));
            access(1'b0, a, '0, '0);
        end

        // conflict on the same line drops the written data
        a_conf = {pool_tag(1), 6'd5, 2'd1, 7'd0};
        access(1'b0, a_conf, '0, '0);
        access(1'b0, a, '0, '0);
        check_word("cpu_data_out", cpu_data_out, mem_word(a));

        for (int n = 0; n < RANDOM_OPS; n++) begin
            a = rand_addr();
            if ($urandom_range(0, 1) == 1) begin
                access(1'b1, a, $urandom, cache_pkg::byte_en_t'($urandom));
            end else begin
                access(1'b0, a, '0, '0);
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/cache_pkg.sv
hw/line_access_if.sv
hw/cache_controller.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_top.sv
tests/cache_assertions.sv
tests/cache_tb.sv
